//--- source/iew_pkg.sv
package iew_pkg;

    // Core widths and sizes
    localparam int XLEN           = 32;
    localparam int NR_AREGS       = 32;
    localparam int NR_PREGS       = 64;
    localparam int NR_ROB_ENTRIES = 8;

    // Index widths derived from the sizes
    localparam int AREG_ID_BITS = $clog2(NR_AREGS);
    localparam int PREG_ID_BITS = $clog2(NR_PREGS);
    localparam int ROB_ID_BITS  = $clog2(NR_ROB_ENTRIES);

    // Two operand ports plus the retire port on the physical file
    localparam int PRF_READ_PORTS = 3;
    localparam int ARF_READ_PORTS = 2;

    typedef logic [XLEN-1:0]         xlen_t;
    typedef logic [AREG_ID_BITS-1:0] areg_id_t;
    typedef logic [PREG_ID_BITS-1:0] preg_id_t;
    // Wraps around the buffer by itself
    typedef logic [ROB_ID_BITS-1:0]  rob_id_t;

endpackage

//--- source/iew_ifs.sv
`timescale 1ns/100ps

// Allocation request from issue into the reorder buffer
interface rob_push_if;
    logic              valid;
    logic              ready;
    iew_pkg::preg_id_t prd;
    iew_pkg::areg_id_t ard;
    logic              rd_valid;
    // Tail index assigned to this push
    iew_pkg::rob_id_t  id;

    modport initiator (
        output valid,
        output prd,
        output ard,
        output rd_valid,
        input  ready
    );

    modport target (
        input  valid,
        input  prd,
        input  ard,
        input  rd_valid,
        output ready,
        output id
    );
endinterface

// Entry leaving the head of the reorder buffer, no back-pressure
interface retire_if;
    logic              valid;
    iew_pkg::preg_id_t prd;
    iew_pkg::areg_id_t ard;
    logic              rd_valid;

    modport source (
        output valid,
        output prd,
        output ard,
        output rd_valid
    );

    // prd goes to the physical file read port at the top level
    modport sink (
        input valid,
        input ard,
        input rd_valid
    );
endinterface

//--- source/reg_file.sv
`timescale 1ns/100ps

module reg_file #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 32,
    parameter int NREAD = 2
) (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic                                we_i,
    input  logic [$clog2(DEPTH)-1:0]            waddr_i,
    input  logic [WIDTH-1:0]                    wdata_i,
    input  logic [NREAD-1:0][$clog2(DEPTH)-1:0] raddr_i,
    output logic [NREAD-1:0][WIDTH-1:0]         rdata_o
);
    logic [WIDTH-1:0] regs [DEPTH];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            regs <= '{default: '0};
        end else if (we_i) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Reads see the old value during a write
    always_comb begin
        for (int i = 0; i < NREAD; i++) begin
            rdata_o[i] = regs[raddr_i[i]];
        end
    end
endmodule

//--- source/scoreboard.sv
`timescale 1ns/100ps

module scoreboard (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    wb_valid_i,
    input  iew_pkg::preg_id_t       wb_prd_i,
    input  logic                    iss_valid_i,
    input  iew_pkg::preg_id_t       iss_prd_i,
    input  iew_pkg::preg_id_t [1:0] raddr_i,
    output logic [1:0]              ready_o
);
    logic [iew_pkg::NR_PREGS-1:0] ready_q;
    logic [iew_pkg::NR_PREGS-1:0] ready_d;

    // Issue clear takes priority over a writeback to the same register
    always_comb begin
        ready_d = ready_q;
        if (wb_valid_i) begin
            ready_d[wb_prd_i] = 1'b1;
        end
        if (iss_valid_i) begin
            ready_d[iss_prd_i] = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ready_q <= '0;
        end else begin
            ready_q <= ready_d;
        end
    end

    // Same-cycle writeback counts as ready
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            ready_o[i] = ready_q[raddr_i[i]] || (wb_valid_i && (wb_prd_i == raddr_i[i]));
        end
    end
endmodule

//--- source/operand_read.sv
`timescale 1ns/100ps

module operand_read (
    input  iew_pkg::preg_id_t    prs1_i,
    input  iew_pkg::preg_id_t    prs2_i,
    input  logic                 renamed1_i,
    input  logic                 renamed2_i,
    input  logic                 rs1_valid_i,
    input  logic                 rs2_valid_i,
    input  iew_pkg::xlen_t       imm_i,
    input  iew_pkg::xlen_t [1:0] prf_rdata_i,
    input  iew_pkg::xlen_t [1:0] arf_rdata_i,
    input  logic [1:0]           sb_ready_i,
    input  logic                 byp_valid_i,
    input  iew_pkg::preg_id_t    byp_prd_i,
    input  iew_pkg::xlen_t       byp_rdval_i,
    output iew_pkg::xlen_t       rs1val_o,
    output iew_pkg::xlen_t       rs2val_o,
    output logic                 operands_ready_o
);
    iew_pkg::preg_id_t [1:0] prs;
    logic [1:0]              renamed;
    iew_pkg::xlen_t [1:0]    fwd_val;
    logic [1:0]              fwd_ready;
    logic                    rs1_ready;
    logic                    rs2_ready;

    assign prs     = {prs2_i, prs1_i};
    assign renamed = {renamed2_i, renamed1_i};

    // Physical file with writeback bypass, or committed state
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            if (renamed[i]) begin
                if (byp_valid_i && (byp_prd_i == prs[i])) begin
                    fwd_val[i]   = byp_rdval_i;
                    fwd_ready[i] = 1'b1;
                end else begin
                    fwd_val[i]   = prf_rdata_i[i];
                    fwd_ready[i] = sb_ready_i[i];
                end
            end else begin
                fwd_val[i]   = arf_rdata_i[i];
                fwd_ready[i] = 1'b1;
            end
        end
    end

    always_comb begin
        rs1val_o  = '0;
        rs1_ready = 1'b1;
        if (rs1_valid_i) begin
            rs1val_o  = fwd_val[0];
            rs1_ready = fwd_ready[0];
        end
        // No rs2 means the immediate takes its slot
        rs2val_o  = imm_i;
        rs2_ready = 1'b1;
        if (rs2_valid_i) begin
            rs2val_o  = fwd_val[1];
            rs2_ready = fwd_ready[1];
        end
    end

    assign operands_ready_o = rs1_ready && rs2_ready;
endmodule

//--- source/issue_ctrl.sv
`timescale 1ns/100ps

module issue_ctrl (
    input  logic              di_valid_i,
    input  logic              operands_ready_i,
    input  logic              fu_ready_i,
    input  logic              rd_valid_i,
    input  iew_pkg::preg_id_t prd_i,
    input  iew_pkg::areg_id_t ard_i,
    output logic              di_ready_o,
    output logic              issue_valid_o,
    output logic              sb_clr_valid_o,
    rob_push_if.initiator     rob_push
);
    logic can_issue;
    logic nostall;

    // Operands, unit and a free reorder buffer slot all needed
    assign can_issue = operands_ready_i && fu_ready_i && rob_push.ready;
    assign nostall   = !di_valid_i || can_issue;

    assign di_ready_o    = nostall;
    assign issue_valid_o = di_valid_i && can_issue;

    // Destination becomes busy until its writeback
    assign sb_clr_valid_o = issue_valid_o && rd_valid_i;

    assign rob_push.valid    = issue_valid_o;
    assign rob_push.prd      = prd_i;
    assign rob_push.ard      = ard_i;
    assign rob_push.rd_valid = rd_valid_i;
endmodule

//--- source/reorder_buffer.sv
`timescale 1ns/100ps

module reorder_buffer (
    input  logic             clk,
    input  logic             rstn,
    rob_push_if.target       push,
    input  logic             cmpl_valid_i,
    input  iew_pkg::rob_id_t cmpl_id_i,
    retire_if.source         retire
);
    localparam int N = iew_pkg::NR_ROB_ENTRIES;

    iew_pkg::rob_id_t  head_q;
    iew_pkg::rob_id_t  tail_q;
    logic [N-1:0]      allocated_q;
    logic [N-1:0]      completed_q;
    iew_pkg::preg_id_t prd_q [N];
    iew_pkg::areg_id_t ard_q [N];
    logic [N-1:0]      rd_valid_q;
    logic              push_fire;
    logic              pop_fire;

    assign push.ready = !allocated_q[tail_q];
    assign push.id    = tail_q;
    assign push_fire  = push.valid && push.ready;

    // Head leaves as soon as it is done
    assign pop_fire = allocated_q[head_q] && completed_q[head_q];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            head_q      <= '0;
            tail_q      <= '0;
            allocated_q <= '0;
            completed_q <= '0;
        end else begin
            if (push_fire) begin
                allocated_q[tail_q] <= 1'b1;
                completed_q[tail_q] <= 1'b0;
                tail_q              <= tail_q + 1'b1;
            end
            if (cmpl_valid_i) begin
                completed_q[cmpl_id_i] <= 1'b1;
            end
            if (pop_fire) begin
                allocated_q[head_q] <= 1'b0;
                head_q              <= head_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_fire) begin
            prd_q[tail_q]      <= push.prd;
            ard_q[tail_q]      <= push.ard;
            rd_valid_q[tail_q] <= push.rd_valid;
        end
    end

    assign retire.valid    = pop_fire;
    assign retire.prd      = prd_q[head_q];
    assign retire.ard      = ard_q[head_q];
    assign retire.rd_valid = rd_valid_q[head_q];
endmodule

//--- source/commit_stage.sv
`timescale 1ns/100ps

module commit_stage (
    input  logic              clk,
    input  logic              rstn,
    retire_if.sink            retire,
    input  iew_pkg::xlen_t    prf_rdata_i,
    output logic              retire_valid_o,
    output iew_pkg::areg_id_t retire_ard_o,
    output logic              retire_rd_valid_o,
    output iew_pkg::xlen_t    retire_rdval_o,
    output logic              arf_we_o,
    output iew_pkg::areg_id_t arf_waddr_o,
    output iew_pkg::xlen_t    arf_wdata_o
);
    logic              valid_q;
    iew_pkg::areg_id_t ard_q;
    logic              rd_valid_q;
    iew_pkg::xlen_t    rdval_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= retire.valid;
        end
    end

    // Physical value captured in the pop cycle
    always_ff @(posedge clk) begin
        ard_q      <= retire.ard;
        rd_valid_q <= retire.rd_valid;
        rdval_q    <= prf_rdata_i;
    end

    assign retire_valid_o    = valid_q;
    assign retire_ard_o      = ard_q;
    assign retire_rd_valid_o = rd_valid_q;
    assign retire_rdval_o    = rdval_q;

    assign arf_we_o    = valid_q && rd_valid_q;
    assign arf_waddr_o = ard_q;
    assign arf_wdata_o = rdval_q;
endmodule

//--- source/iew_top.sv
`timescale 1ns/100ps

module iew_top (
    input  logic              clk,
    input  logic              rstn,
    // Dispatch from rename
    input  logic              di_valid_i,
    input  iew_pkg::preg_id_t di_prs1_i,
    input  iew_pkg::preg_id_t di_prs2_i,
    input  logic              di_prs1_renamed_i,
    input  logic              di_prs2_renamed_i,
    input  iew_pkg::areg_id_t di_rs1_i,
    input  iew_pkg::areg_id_t di_rs2_i,
    input  logic              di_rs1_valid_i,
    input  logic              di_rs2_valid_i,
    input  logic              di_rd_valid_i,
    input  iew_pkg::areg_id_t di_ard_i,
    input  iew_pkg::preg_id_t di_prd_i,
    input  iew_pkg::xlen_t    di_imm_i,
    input  logic              fu_ready_i,
    // Writeback and completion from execute
    input  logic              wb_valid_i,
    input  iew_pkg::preg_id_t wb_prd_i,
    input  iew_pkg::xlen_t    wb_rdval_i,
    input  logic              cmpl_valid_i,
    input  iew_pkg::rob_id_t  cmpl_id_i,
    // Issue to execute
    output logic              di_ready_o,
    output logic              issue_valid_o,
    output iew_pkg::xlen_t    issue_rs1val_o,
    output iew_pkg::xlen_t    issue_rs2val_o,
    output iew_pkg::preg_id_t issue_prd_o,
    output iew_pkg::rob_id_t  issue_rob_id_o,
    // Retired instruction
    output logic              retire_valid_o,
    output iew_pkg::areg_id_t retire_ard_o,
    output logic              retire_rd_valid_o,
    output iew_pkg::xlen_t    retire_rdval_o
);
    iew_pkg::preg_id_t [iew_pkg::PRF_READ_PORTS-1:0] prf_raddr;
    iew_pkg::xlen_t [iew_pkg::PRF_READ_PORTS-1:0]    prf_rdata;
    iew_pkg::areg_id_t [iew_pkg::ARF_READ_PORTS-1:0] arf_raddr;
    iew_pkg::xlen_t [iew_pkg::ARF_READ_PORTS-1:0]    arf_rdata;
    logic [1:0]                                      sb_ready;
    logic                                            operands_ready;
    logic                                            sb_clr_valid;
    logic                                            arf_we;
    iew_pkg::areg_id_t                               arf_waddr;
    iew_pkg::xlen_t                                  arf_wdata;

    rob_push_if rob_push_bus ();
    retire_if   retire_bus ();

    // Operand ports 0 and 1, retire port 2
    assign prf_raddr = {retire_bus.prd, di_prs2_i, di_prs1_i};
    assign arf_raddr = {di_rs2_i, di_rs1_i};

    reg_file #(
        .WIDTH (iew_pkg::XLEN),
        .DEPTH (iew_pkg::NR_PREGS),
        .NREAD (iew_pkg::PRF_READ_PORTS)
    ) prf (
        .clk     (clk),
        .rstn    (rstn),
        .we_i    (wb_valid_i),
        .waddr_i (wb_prd_i),
        .wdata_i (wb_rdval_i),
        .raddr_i (prf_raddr),
        .rdata_o (prf_rdata)
    );

    reg_file #(
        .WIDTH (iew_pkg::XLEN),
        .DEPTH (iew_pkg::NR_AREGS),
        .NREAD (iew_pkg::ARF_READ_PORTS)
    ) arf (
        .clk     (clk),
        .rstn    (rstn),
        .we_i    (arf_we),
        .waddr_i (arf_waddr),
        .wdata_i (arf_wdata),
        .raddr_i (arf_raddr),
        .rdata_o (arf_rdata)
    );

    scoreboard scoreboard_i (
        .clk         (clk),
        .rstn        (rstn),
        .wb_valid_i  (wb_valid_i),
        .wb_prd_i    (wb_prd_i),
        .iss_valid_i (sb_clr_valid),
        .iss_prd_i   (di_prd_i),
        .raddr_i     (prf_raddr[1:0]),
        .ready_o     (sb_ready)
    );

    operand_read operand_read_i (
        .prs1_i           (di_prs1_i),
        .prs2_i           (di_prs2_i),
        .renamed1_i       (di_prs1_renamed_i),
        .renamed2_i       (di_prs2_renamed_i),
        .rs1_valid_i      (di_rs1_valid_i),
        .rs2_valid_i      (di_rs2_valid_i),
        .imm_i            (di_imm_i),
        .prf_rdata_i      (prf_rdata[1:0]),
        .arf_rdata_i      (arf_rdata),
        .sb_ready_i       (sb_ready),
        .byp_valid_i      (wb_valid_i),
        .byp_prd_i        (wb_prd_i),
        .byp_rdval_i      (wb_rdval_i),
        .rs1val_o         (issue_rs1val_o),
        .rs2val_o         (issue_rs2val_o),
        .operands_ready_o (operands_ready)
    );

    issue_ctrl issue_ctrl_i (
        .di_valid_i       (di_valid_i),
        .operands_ready_i (operands_ready),
        .fu_ready_i       (fu_ready_i),
        .rd_valid_i       (di_rd_valid_i),
        .prd_i            (di_prd_i),
        .ard_i            (di_ard_i),
        .di_ready_o       (di_ready_o),
        .issue_valid_o    (issue_valid_o),
        .sb_clr_valid_o   (sb_clr_valid),
        .rob_push         (rob_push_bus.initiator)
    );

    assign issue_prd_o    = di_prd_i;
    assign issue_rob_id_o = rob_push_bus.id;

    reorder_buffer reorder_buffer_i (
        .clk          (clk),
        .rstn         (rstn),
        .push         (rob_push_bus.target),
        .cmpl_valid_i (cmpl_valid_i),
        .cmpl_id_i    (cmpl_id_i),
        .retire       (retire_bus.source)
    );

    commit_stage commit_stage_i (
        .clk               (clk),
        .rstn              (rstn),
        .retire            (retire_bus.sink),
        .prf_rdata_i       (prf_rdata[2]),
        .retire_valid_o    (retire_valid_o),
        .retire_ard_o      (retire_ard_o),
        .retire_rd_valid_o (retire_rd_valid_o),
        .retire_rdval_o    (retire_rdval_o),
        .arf_we_o          (arf_we),
        .arf_waddr_o       (arf_waddr),
        .arf_wdata_o       (arf_wdata)
    );
endmodule

//--- tb/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk_o,
    output logic rstn_o
);
    // 20 ns period
    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;
    end

    initial begin
        rstn_o = 1'b0;
        repeat (16) @(posedge clk_o);
        rstn_o <= 1'b1;
    end
endmodule

//--- tb/iew_assertions.sv
`timescale 1ns/100ps

module iew_assertions (
    input logic clk,
    input logic rstn,
    input logic di_valid_i,
    input logic di_ready_o,
    input logic fu_ready_i,
    input logic issue_valid_o,
    input logic retire_valid_o,
    input logic rob_ready_i
);
    int unsigned fail_count = 0;

    // Busy unit blocks issue
    a_fu_gate: assert property (@(posedge clk) disable iff (!rstn)
        !fu_ready_i |-> !issue_valid_o)
        else begin
            fail_count++;
            $error("instruction issued while the functional unit was busy");
        end

    a_issue_handshake: assert property (@(posedge clk) disable iff (!rstn)
        issue_valid_o |-> (di_valid_i && di_ready_o))
        else begin
            fail_count++;
            $error("issue strobe without an accepted dispatch");
        end

    // Full reorder buffer holds the dispatch
    a_rob_full_hold: assert property (@(posedge clk) disable iff (!rstn)
        (!rob_ready_i && di_valid_i) |-> (!di_ready_o && !issue_valid_o))
        else begin
            fail_count++;
            $error("dispatch accepted while the reorder buffer tail was busy");
        end

    a_idle_ready: assert property (@(posedge clk) disable iff (!rstn)
        !di_valid_i |-> di_ready_o)
        else begin
            fail_count++;
            $error("dispatch ready dropped with no dispatch offered");
        end

    a_reset_retire: assert property (@(posedge clk)
        !rstn |=> !retire_valid_o)
        else begin
            fail_count++;
            $error("retire valid high right after reset");
        end
endmodule

bind iew_top iew_assertions iew_assertions_i (
    .clk            (clk),
    .rstn           (rstn),
    .di_valid_i     (di_valid_i),
    .di_ready_o     (di_ready_o),
    .fu_ready_i     (fu_ready_i),
    .issue_valid_o  (issue_valid_o),
    .retire_valid_o (retire_valid_o),
    .rob_ready_i    (rob_push_bus.ready)
);

//--- tb/iew_tb.sv
`timescale 1ns/100ps

module iew_tb;
    localparam int TIMEOUT_CYCLES = 2000;

    typedef struct {
        iew_pkg::areg_id_t ard;
        logic              rd_valid;
        iew_pkg::preg_id_t prd;
    } entry_t;

    logic clk;
    logic rstn;
    logic di_valid_i;
    iew_pkg::preg_id_t di_prs1_i;
    iew_pkg::preg_id_t di_prs2_i;
    logic di_prs1_renamed_i;
    logic di_prs2_renamed_i;
    iew_pkg::areg_id_t di_rs1_i;
    iew_pkg::areg_id_t di_rs2_i;
    logic di_rs1_valid_i;
    logic di_rs2_valid_i;
    logic di_rd_valid_i;
    iew_pkg::areg_id_t di_ard_i;
    iew_pkg::preg_id_t di_prd_i;
    iew_pkg::xlen_t di_imm_i;
    logic fu_ready_i;
    logic wb_valid_i;
    iew_pkg::preg_id_t wb_prd_i;
    iew_pkg::xlen_t wb_rdval_i;
    logic cmpl_valid_i;
    iew_pkg::rob_id_t cmpl_id_i;
    logic di_ready_o;
    logic issue_valid_o;
    iew_pkg::xlen_t issue_rs1val_o;
    iew_pkg::xlen_t issue_rs2val_o;
    iew_pkg::preg_id_t issue_prd_o;
    iew_pkg::rob_id_t issue_rob_id_o;
    logic retire_valid_o;
    iew_pkg::areg_id_t retire_ard_o;
    logic retire_rd_valid_o;
    iew_pkg::xlen_t retire_rdval_o;

    // Reference state
    entry_t           expected[$];
    iew_pkg::xlen_t   prf_model [iew_pkg::NR_PREGS];
    iew_pkg::xlen_t   arf_model [iew_pkg::NR_AREGS];
    iew_pkg::rob_id_t rob_tail = '0;
    logic [15:0]      lfsr = 16'd47;
    string            test_name = "reset";
    int               cycles = 0;

    tb_clock_gen clock_gen_i (
        .clk_o  (clk),
        .rstn_o (rstn)
    );

    iew_top iew_top_i (.*);

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (exp == act)
        else fail_run($sformatf("Mismatch %s %s expected %h actual %h", test_name, what, exp, act));
    endtask

    // Galois LFSR, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic drive_dispatch(
        input logic r1v, input logic ren1, input iew_pkg::preg_id_t p1, input iew_pkg::areg_id_t a1,
        input logic r2v, input logic ren2, input iew_pkg::preg_id_t p2, input iew_pkg::areg_id_t a2,
        input logic rdv, input iew_pkg::areg_id_t ard, input iew_pkg::preg_id_t prd,
        input iew_pkg::xlen_t imm
    );
        @(posedge clk);
        di_valid_i        <= 1'b1;
        di_rs1_valid_i    <= r1v;
        di_prs1_renamed_i <= ren1;
        di_prs1_i         <= p1;
        di_rs1_i          <= a1;
        di_rs2_valid_i    <= r2v;
        di_prs2_renamed_i <= ren2;
        di_prs2_i         <= p2;
        di_rs2_i          <= a2;
        di_rd_valid_i     <= rdv;
        di_ard_i          <= ard;
        di_prd_i          <= prd;
        di_imm_i          <= imm;
    endtask

    task automatic wait_issue(output iew_pkg::rob_id_t id, output iew_pkg::xlen_t v1,
                              output iew_pkg::xlen_t v2);
        @(negedge clk);
        while (!issue_valid_o) @(negedge clk);
        id = issue_rob_id_o;
        v1 = issue_rs1val_o;
        v2 = issue_rs2val_o;
        @(posedge clk);
        di_valid_i   <= 1'b0;
        wb_valid_i   <= 1'b0;
        cmpl_valid_i <= 1'b0;
    endtask

    // Writeback and completion in the same cycle
    task automatic execute(input iew_pkg::rob_id_t id, input logic wb,
                           input iew_pkg::preg_id_t prd, input iew_pkg::xlen_t val);
        @(posedge clk);
        wb_valid_i   <= wb;
        wb_prd_i     <= prd;
        wb_rdval_i   <= val;
        cmpl_valid_i <= 1'b1;
        cmpl_id_i    <= id;
        @(posedge clk);
        wb_valid_i   <= 1'b0;
        cmpl_valid_i <= 1'b0;
    endtask

    task automatic drain;
        while (expected.size() != 0) @(negedge clk);
        repeat (2) @(negedge clk);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            fail_run("Timeout: the tests did not finish within the cycle limit");
        end
    end

    // Retire check first, then record issue and writeback
    always @(negedge clk) begin
        entry_t e;
        if (rstn && retire_valid_o) begin
            assert (expected.size() != 0)
            else fail_run("Retire seen with no issued instruction outstanding");
            e = expected.pop_front();
            check_value("retire_ard", e.ard, retire_ard_o);
            check_value("retire_rd_valid", e.rd_valid, retire_rd_valid_o);
            check_value("retire_rdval", prf_model[e.prd], retire_rdval_o);
            if (e.rd_valid) begin
                arf_model[e.ard] = prf_model[e.prd];
            end
        end
        if (rstn && issue_valid_o) begin
            // Ids follow the tail from an empty buffer
            check_value("issue_rob_id", rob_tail, issue_rob_id_o);
            check_value("issue_prd", di_prd_i, issue_prd_o);
            rob_tail   = rob_tail + 1'b1;
            e.ard      = di_ard_i;
            e.rd_valid = di_rd_valid_i;
            e.prd      = di_prd_i;
            expected.push_back(e);
        end
        if (rstn && wb_valid_i) begin
            prf_model[wb_prd_i] = wb_rdval_i;
        end
    end

    initial begin
        iew_pkg::rob_id_t  id;
        iew_pkg::rob_id_t  ids [9];
        iew_pkg::xlen_t    v1;
        iew_pkg::xlen_t    v2;
        iew_pkg::xlen_t    val;
        iew_pkg::xlen_t    imm;
        iew_pkg::preg_id_t pa;
        iew_pkg::preg_id_t pd;
        iew_pkg::areg_id_t ards [3];
        iew_pkg::preg_id_t prds [3];

        for (int i = 0; i < iew_pkg::NR_PREGS; i++) prf_model[i] = '0;
        for (int i = 0; i < iew_pkg::NR_AREGS; i++) arf_model[i] = '0;
        di_valid_i <= 1'b0;
        di_prs1_i <= '0;
        di_prs2_i <= '0;
        di_prs1_renamed_i <= 1'b0;
        di_prs2_renamed_i <= 1'b0;
        di_rs1_i <= '0;
        di_rs2_i <= '0;
        di_rs1_valid_i <= 1'b0;
        di_rs2_valid_i <= 1'b0;
        di_rd_valid_i <= 1'b0;
        di_ard_i <= '0;
        di_prd_i <= '0;
        di_imm_i <= '0;
        fu_ready_i <= 1'b1;
        wb_valid_i <= 1'b0;
        wb_prd_i <= '0;
        wb_rdval_i <= '0;
        cmpl_valid_i <= 1'b0;
        cmpl_id_i <= '0;
        wait (rstn);

        // Idle after reset, committed state reads zero
        test_name = "reset_idle";
        @(posedge clk);
        di_rs1_valid_i <= 1'b1;
        di_rs1_i       <= iew_pkg::areg_id_t'(rand_bits(5));
        repeat (4) begin
            @(negedge clk);
            check_value("issue_valid", 0, issue_valid_o);
            check_value("retire_valid", 0, retire_valid_o);
            check_value("rs1val", 0, issue_rs1val_o);
        end

        // Hold on an unwritten source, then issue off the bypass
        test_name = "bypass_issue";
        pa  = iew_pkg::preg_id_t'(rand_bits(6));
        pd  = pa ^ 6'h20;
        imm = rand_bits(32);
        drive_dispatch(1, 1, pa, 0, 0, 0, 0, 0, 1, iew_pkg::areg_id_t'(rand_bits(5)), pd, imm);
        repeat (3) begin
            @(negedge clk);
            assert (!di_ready_o && !issue_valid_o)
            else fail_run("Dispatch with an unwritten source was not held");
        end
        val = rand_bits(32);
        @(posedge clk);
        wb_valid_i <= 1'b1;
        wb_prd_i   <= pa;
        wb_rdval_i <= val;
        // Issue lands in the writeback cycle itself
        @(negedge clk);
        check_value("issue_valid", 1, issue_valid_o);
        check_value("rs1val", val, issue_rs1val_o);
        check_value("rs2val", imm, issue_rs2val_o);
        id = issue_rob_id_o;
        @(posedge clk);
        di_valid_i <= 1'b0;
        wb_valid_i <= 1'b0;
        execute(id, 1, pd, rand_bits(32));
        drain();

        // Written register read back, immediate in the rs2 slot
        test_name = "prf_read";
        imm = rand_bits(32);
        drive_dispatch(1, 1, pa, 0, 0, 0, 0, 0, 0, 0, pd, imm);
        wait_issue(id, v1, v2);
        check_value("rs1val", val, v1);
        check_value("rs2val", imm, v2);
        execute(id, 0, 0, 0);
        drive_dispatch(0, 0, 0, 0, 1, 1, pd, 0, 0, 0, pa, 0);
        wait_issue(id, v1, v2);
        check_value("rs2val", prf_model[pd], v2);
        execute(id, 0, 0, 0);
        drain();

        // Completed out of order, retired in issue order
        test_name = "out_of_order";
        pd = iew_pkg::preg_id_t'(rand_bits(6));
        for (int k = 0; k < 3; k++) begin
            ards[k] = iew_pkg::areg_id_t'(rand_bits(5));
            prds[k] = pd + iew_pkg::preg_id_t'(k);
            drive_dispatch(1, 0, 0, ards[k], 0, 0, 0, 0, 1, ards[k], prds[k], 0);
            wait_issue(ids[k], v1, v2);
            check_value("rs1val", arf_model[ards[k]], v1);
        end
        execute(ids[2], 1, prds[2], rand_bits(32));
        execute(ids[0], 1, prds[0], rand_bits(32));
        execute(ids[1], 1, prds[1], rand_bits(32));
        drain();

        // Committed values visible to non-renamed reads
        test_name = "arf_visible";
        for (int k = 0; k < 3; k++) begin
            @(posedge clk);
            di_rs1_valid_i    <= 1'b1;
            di_prs1_renamed_i <= 1'b0;
            di_rs1_i          <= ards[k];
            @(negedge clk);
            check_value("rs1val", arf_model[ards[k]], issue_rs1val_o);
        end

        // Eight outstanding entries block the ninth
        test_name = "rob_full";
        for (int k = 0; k < 8; k++) begin
            drive_dispatch(0, 0, 0, 0, 0, 0, 0, 0, 0, 0, iew_pkg::preg_id_t'(rand_bits(6)), 0);
            wait_issue(ids[k], v1, v2);
        end
        drive_dispatch(0, 0, 0, 0, 0, 0, 0, 0, 0, 0, iew_pkg::preg_id_t'(rand_bits(6)), 0);
        repeat (3) begin
            @(negedge clk);
            assert (!di_ready_o)
            else fail_run("Ninth dispatch accepted with the reorder buffer full");
        end
        execute(ids[0], 0, 0, 0);
        wait_issue(ids[8], v1, v2);
        for (int k = 1; k < 9; k++) begin
            execute(ids[k], 0, 0, 0);
        end
        drain();

        // No issue while the unit is busy
        test_name = "fu_busy";
        @(posedge clk);
        fu_ready_i <= 1'b0;
        drive_dispatch(0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, rand_bits(32));
        repeat (4) begin
            @(negedge clk);
            check_value("issue_valid", 0, issue_valid_o);
        end
        @(posedge clk);
        fu_ready_i <= 1'b1;
        wait_issue(id, v1, v2);
        execute(id, 0, 0, 0);
        drain();

        if (iew_top_i.iew_assertions_i.fail_count == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            fail_run("Protocol assertions failed during the run");
        end
    end
endmodule

//--- list.f
source/iew_pkg.sv
source/iew_ifs.sv
source/reg_file.sv
source/scoreboard.sv
source/operand_read.sv
source/issue_ctrl.sv
source/reorder_buffer.sv
source/commit_stage.sv
source/iew_top.sv
tb/tb_clock_gen.sv
tb/iew_assertions.sv
tb/iew_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing --top-module iew_tb -f list.f -o iew_sim
out=$(./obj_dir/iew_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -q "Result: PASSED"; then
    exit 0
fi
exit 1
